//--- Bender.yml
package:
  name: tile_control

sources:
  - files:
      - hdl/tile_pkg.sv
      - hdl/tile_cycle_status.sv
      - hdl/lvt_rolling_min.sv
      - hdl/lvt_reduce.sv
      - hdl/finish_select.sv
      - hdl/tile_control.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tile_control_tb.sv

//--- files.f
+incdir+verif
hdl/tile_pkg.sv
hdl/tile_cycle_status.sv
hdl/lvt_rolling_min.sv
hdl/lvt_reduce.sv
hdl/finish_select.sv
hdl/tile_control.sv
verif/tile_control_tb.sv

//--- hdl/finish_select.sv
`timescale 1ns/1ps
`default_nettype none

module finish_select
   import tile_pkg::*;
(
   input  wire logic                             [n_threads-1:0] thread_valid,
   input  wire finish_req_t                      [n_threads-1:0] thread_req,
   input  wire logic                      [undo_log_threads-1:0] restore_valid,
   input  wire cq_slot_t                  [undo_log_threads-1:0] restore_slot,
   input  wire logic                                             cq_ready,

   output logic                                                  sel_valid,
   output finish_sel_t                                           sel,
   output logic                                  [n_threads-1:0] thread_ready,
   output logic                           [undo_log_threads-1:0] restore_ready
);

   logic        [finish_ports-1:0] all_valid;
   logic        [finish_ports-1:0] all_ready;
   finish_req_t [finish_ports-1:0] all_req;
   core_sel_t                      win_idx;

   assign all_valid = {restore_valid, thread_valid};

   // Restore threads finish with no children and no undo-log write
   always_comb begin
      for (int i = 0; i < n_threads; i++) begin
         all_req[i] = thread_req[i];
      end
      for (int i = 0; i < undo_log_threads; i++) begin
         all_req[n_threads+i].slot           = restore_slot[i];
         all_req[n_threads+i].num_children   = '0;
         all_req[n_threads+i].undo_log_write = 1'b0;
      end
   end

   // Lowest valid index wins
   always_comb begin
      win_idx = '0;
      for (int i = finish_ports - 1; i >= 0; i--) begin
         if (all_valid[i]) begin
            win_idx = core_sel_t'(i);
         end
      end
   end

   always_comb begin
      sel_valid          = |all_valid;
      sel.core           = win_idx;
      sel.slot           = all_req[win_idx].slot;
      sel.num_children   = all_req[win_idx].num_children;
      sel.undo_log_write = all_req[win_idx].undo_log_write;
      sel.is_restore     = (win_idx >= core_sel_t'(n_threads));
   end

   // Ready only to the winner, and only when the commit queue takes it
   for (genvar i = 0; i < finish_ports; i++) begin : g_ready
      assign all_ready[i] = sel_valid & cq_ready & (win_idx == core_sel_t'(i));
   end

   assign thread_ready  = all_ready[n_threads-1:0];
   assign restore_ready = all_ready[finish_ports-1:n_threads];

   // A ready never goes to more than one requester, nor to an idle one
   always_comb begin
      assert final ($onehot0(all_ready) && ((all_ready & ~all_valid) == '0))
      else $error("finish ready given to more than one or to an idle requester");
   end

endmodule

`default_nettype wire

//--- hdl/lvt_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module lvt_reduce
   import tile_pkg::*;
(
   input  wire logic   clk_main_a0,
   input  wire logic   rst_main_n_sync,

   input  wire phase_t phase,
   input  wire tb_t    cur_tb,

   input  wire ts_t    tq_ts,
   input  wire ts_t    cm_ts,
   input  wire ts_t    splitter_ts,
   input  wire ts_t    tsb_ts,
   input  wire vt_u    cq_vt,

   output vt_u         lvt
);

   vt_u tq_vt, cm_vt, splitter_vt, tsb_vt;
   vt_u tq_cq_min, cm_tsb_min, quad_min;

   function automatic vt_u vt_min(vt_u a, vt_u b);
      return (a.raw < b.raw) ? a : b;
   endfunction

   // Time stamps become virtual times at the current time base
   always_comb begin
      tq_vt.fields.ts       = tq_ts;
      tq_vt.fields.tb       = cur_tb;
      cm_vt.fields.ts       = cm_ts;
      cm_vt.fields.tb       = cur_tb;
      splitter_vt.fields.ts = splitter_ts;
      splitter_vt.fields.tb = cur_tb;
      tsb_vt.fields.ts      = tsb_ts;
      tsb_vt.fields.tb      = cur_tb;
   end

   // Each tree stage registers at its own phase
   always_ff @(posedge clk_main_a0) begin
      if (phase == pair_min_phase) begin
         tq_cq_min  <= vt_min(tq_vt, cq_vt);
         cm_tsb_min <= vt_min(cm_vt, tsb_vt);
      end
      if (phase == quad_min_phase) begin
         quad_min <= vt_min(tq_cq_min, cm_tsb_min);
      end
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         lvt <= '0;
      end else if (phase == lvt_publish_phase) begin
         lvt <= vt_min(quad_min, splitter_vt);
      end
   end

   // Only the publish stage may move the tile LVT
   assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      !$stable(lvt) |-> ($past(phase) == lvt_publish_phase))
   else $error("lvt changed outside the publish phase");

endmodule

`default_nettype wire

//--- hdl/lvt_rolling_min.sv
`timescale 1ns/1ps
`default_nettype none

module lvt_rolling_min
   import tile_pkg::*;
#(
   parameter phase_t SAMPLE_PHASE = '0
) (
   input  wire logic   clk_main_a0,
   input  wire logic   rst_main_n_sync,

   input  wire phase_t phase,
   input  wire ts_t    src_ts,

   output ts_t         fixed_ts
);

   ts_t  rolling_ts;
   logic at_sample;

   assign at_sample = (phase == SAMPLE_PHASE);

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         rolling_ts <= '0;
         fixed_ts   <= '0;
      end else if (at_sample) begin
         // Publish last period's minimum and restart from the source
         fixed_ts   <= rolling_ts;
         rolling_ts <= src_ts;
      end else if (src_ts < rolling_ts) begin
         rolling_ts <= src_ts;
      end
   end

   // Between sample points the running minimum only goes down
   assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      !$past(at_sample) |-> (rolling_ts <= $past(rolling_ts)))
   else $error("rolling minimum rose outside the sample phase");

endmodule

`default_nettype wire

//--- hdl/tile_control.sv
`timescale 1ns/1ps
`default_nettype none

module tile_control
   import tile_pkg::*;
(
   input  wire logic                             clk_main_a0,
   input  wire logic                             rst_main_n_sync,

   // LVT reports of the surrounding tile blocks
   input  wire lvt_sources_t                     lvt_src,

   input  wire logic                             tq_empty,
   input  wire logic                             tsb_empty,
   input  wire logic                             all_cores_idle,

   // Finishing requesters toward the commit queue
   input  wire logic             [n_threads-1:0] thread_valid,
   input  wire finish_req_t      [n_threads-1:0] thread_req,
   input  wire logic      [undo_log_threads-1:0] restore_valid,
   input  wire cq_slot_t  [undo_log_threads-1:0] restore_slot,
   input  wire logic                             cq_ready,

   output logic                                  sel_valid,
   output finish_sel_t                           sel,
   output logic                  [n_threads-1:0] thread_ready,
   output logic           [undo_log_threads-1:0] restore_ready,

   output vt_u                                   lvt,
   output logic                                  done
);

   phase_t phase;
   tb_t    cur_tb;

   ts_t tq_fixed_ts;
   ts_t cm_fixed_ts;
   ts_t splitter_fixed_ts;

   tile_cycle_status CYCLE_STATUS (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .tq_empty        (tq_empty),
      .tsb_empty       (tsb_empty),
      .all_cores_idle  (all_cores_idle),
      .phase           (phase),
      .cur_tb          (cur_tb),
      .done            (done)
   );

   // Per-source minima over each GVT period
   lvt_rolling_min #(
      .SAMPLE_PHASE(tq_sample_phase)
   ) TQ_LVT (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .phase           (phase),
      .src_ts          (lvt_src.tq_ts),
      .fixed_ts        (tq_fixed_ts)
   );

   lvt_rolling_min #(
      .SAMPLE_PHASE(cm_sample_phase)
   ) CM_LVT (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .phase           (phase),
      .src_ts          (lvt_src.cm_ts),
      .fixed_ts        (cm_fixed_ts)
   );

   lvt_rolling_min #(
      .SAMPLE_PHASE(splitter_sample_phase)
   ) SPLITTER_LVT (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .phase           (phase),
      .src_ts          (lvt_src.splitter_ts),
      .fixed_ts        (splitter_fixed_ts)
   );

   // CQ and TSB report directly into the tree
   lvt_reduce LVT_REDUCE (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .phase           (phase),
      .cur_tb          (cur_tb),
      .tq_ts           (tq_fixed_ts),
      .cm_ts           (cm_fixed_ts),
      .splitter_ts     (splitter_fixed_ts),
      .tsb_ts          (lvt_src.tsb_ts),
      .cq_vt           (lvt_src.cq_vt),
      .lvt             (lvt)
   );

   finish_select FINISH_SELECT (
      .thread_valid    (thread_valid),
      .thread_req      (thread_req),
      .restore_valid   (restore_valid),
      .restore_slot    (restore_slot),
      .cq_ready        (cq_ready),
      .sel_valid       (sel_valid),
      .sel             (sel),
      .thread_ready    (thread_ready),
      .restore_ready   (restore_ready)
   );

endmodule

`default_nettype wire

//--- hdl/tile_cycle_status.sv
`timescale 1ns/1ps
`default_nettype none

module tile_cycle_status
   import tile_pkg::*;
(
   input  wire logic clk_main_a0,
   input  wire logic rst_main_n_sync,

   input  wire logic tq_empty,
   input  wire logic tsb_empty,
   input  wire logic all_cores_idle,

   output phase_t    phase,
   output tb_t       cur_tb,
   output logic      done
);

   logic [cycle_width-1:0] cur_cycle;
   logic                   tile_quiet;

   assign tile_quiet = tq_empty & tsb_empty & all_cores_idle;

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         cur_cycle <= '0;
         done      <= 1'b0;
      end else begin
         cur_cycle <= cur_cycle + 1'b1;
         done      <= tile_quiet;
      end
   end

   assign phase = cur_cycle[log_gvt_period-1:0];

   // The LVT refers to the start of the previous GVT period
   assign cur_tb[tb_width-1:log_gvt_period] = cur_cycle[tb_width-1:log_gvt_period] - 1'b1;
   assign cur_tb[log_gvt_period-1:0]        = '0;

   // A rising done must come from a cycle where the tile was quiet
   assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      $rose(done) |-> $past(tile_quiet))
   else $error("done rose without tq, tsb and cores all idle");

endmodule

`default_nettype wire

//--- hdl/tile_pkg.sv
`default_nettype none

package tile_pkg;

   // Widths
   localparam int ts_width       = 32;
   localparam int tb_width       = 32;
   localparam int log_gvt_period = 4;
   localparam int cycle_width    = 64;

   // Finish requesters count worker threads before restore threads
   localparam int n_threads        = 4;
   localparam int undo_log_threads = 2;
   localparam int finish_ports     = n_threads + undo_log_threads;
   localparam int core_sel_width   = $clog2(finish_ports);

   localparam int cq_slot_width  = 6;
   localparam int child_id_width = 3;

   typedef logic [ts_width-1:0]       ts_t;
   typedef logic [tb_width-1:0]       tb_t;
   typedef logic [log_gvt_period-1:0] phase_t;
   typedef logic [cq_slot_width-1:0]  cq_slot_t;
   typedef logic [child_id_width-1:0] child_id_t;
   typedef logic [core_sel_width-1:0] core_sel_t;

   // Phases within the GVT period
   localparam phase_t tq_sample_phase       = phase_t'(2);
   localparam phase_t cm_sample_phase       = phase_t'(0);
   localparam phase_t splitter_sample_phase = phase_t'(0);
   localparam phase_t pair_min_phase        = phase_t'(8);
   localparam phase_t quad_min_phase        = phase_t'(9);
   localparam phase_t lvt_publish_phase     = phase_t'(10);

   typedef struct packed {
      ts_t ts;
      tb_t tb;
   } vt_fields_t;

   // Ordered as one word, built from its two fields
   typedef union packed {
      logic [ts_width+tb_width-1:0] raw;
      vt_fields_t                   fields;
   } vt_u;

   typedef struct packed {
      ts_t tq_ts;
      ts_t cm_ts;
      ts_t splitter_ts;
      vt_u cq_vt;
      ts_t tsb_ts;
   } lvt_sources_t;

   typedef struct packed {
      cq_slot_t  slot;
      child_id_t num_children;
      logic      undo_log_write;
   } finish_req_t;

   typedef struct packed {
      core_sel_t core;
      cq_slot_t  slot;
      child_id_t num_children;
      logic      undo_log_write;
      logic      is_restore;
   } finish_sel_t;

endpackage

`default_nettype wire

//--- verif/tile_control_checks.svh
`ifndef TILE_CONTROL_CHECKS_SVH
`define TILE_CONTROL_CHECKS_SVH

// Compare tasks for the testbench top module

task automatic report_error(input string msg);
   error_count++;
   $display("Error at %0t ns: %s", $time, msg);
   fail_run();
endtask

task automatic check_vt(input string what, input vt_u got, input vt_u exp);
   if (got !== exp) begin
      report_error($sformatf("%s: ts %h tb %h, expected ts %h tb %h", what,
         got.fields.ts, got.fields.tb, exp.fields.ts, exp.fields.tb));
   end
endtask

task automatic check_finish(
   input string                       what,
   input logic                        got_valid,
   input finish_sel_t                 got_sel,
   input logic [n_threads-1:0]        got_thread_ready,
   input logic [undo_log_threads-1:0] got_restore_ready,
   input logic                        exp_valid,
   input finish_sel_t                 exp_sel,
   input logic [n_threads-1:0]        exp_thread_ready,
   input logic [undo_log_threads-1:0] exp_restore_ready
);
   if (got_valid !== exp_valid) begin
      report_error($sformatf("%s: sel_valid %b, expected %b", what, got_valid, exp_valid));
   end
   // Selection fields mean nothing while no requester is valid
   if (exp_valid && (got_sel !== exp_sel)) begin
      report_error($sformatf("%s: sel %h, expected %h", what, got_sel, exp_sel));
   end
   if ((got_thread_ready !== exp_thread_ready) || (got_restore_ready !== exp_restore_ready)) begin
      report_error($sformatf("%s: ready %b/%b, expected %b/%b", what, got_restore_ready,
         got_thread_ready, exp_restore_ready, exp_thread_ready));
   end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
   if (got !== exp) begin
      report_error($sformatf("%s: got %b, expected %b", what, got, exp));
   end
endtask

`endif

//--- verif/tile_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tile_control_tb
   import tile_pkg::*;
();

   localparam int clk_period      = 20;
   localparam int n_rows          = 6;
   localparam int lvt_hold_cycles = 3 * (1 << log_gvt_period);
   localparam int watchdog_ns     = n_rows * lvt_hold_cycles * clk_period + 1000;

   typedef struct packed {
      ts_t                         tq_ts;
      ts_t                         cm_ts;
      ts_t                         splitter_ts;
      ts_t                         tsb_ts;
      ts_t                         cq_ts;
      tb_t                         cq_tb;
      logic                        tq_empty;
      logic                        tsb_empty;
      logic                        all_cores_idle;
      logic [n_threads-1:0]        thread_valid;
      logic [undo_log_threads-1:0] restore_valid;
      logic                        cq_ready;
      core_sel_t                   exp_core;
      logic                        exp_done;
   } stim_t;

   // tq, cm, splitter, tsb, cq ts, cq tb
   // tq_empty, tsb_empty, idle, thread valid, restore valid, cq_ready, winner, done
   localparam stim_t stim_table [n_rows] = '{
      '{32'h500, 32'h400, 32'h300, 32'h200, 32'h100, 32'h77,
        1'b1, 1'b1, 1'b1, 4'b0110, 2'b01, 1'b1, 3'd1, 1'b1},
      '{32'h120, 32'h340, 32'h560, 32'h780, 32'h9a0, 32'h10,
        1'b1, 1'b0, 1'b1, 4'b0000, 2'b11, 1'b1, 3'd4, 1'b0},
      '{32'h900, 32'h050, 32'h700, 32'h600, 32'h800, 32'h0,
        1'b1, 1'b1, 1'b1, 4'b1000, 2'b10, 1'b0, 3'd3, 1'b1},
      '{32'h640, 32'h630, 32'h020, 32'h610, 32'h650, 32'h3,
        1'b0, 1'b1, 1'b1, 4'b0000, 2'b10, 1'b1, 3'd5, 1'b0},
      '{32'h444, 32'h333, 32'h222, 32'h011, 32'h555, 32'h9,
        1'b1, 1'b1, 1'b0, 4'b0000, 2'b00, 1'b1, 3'd0, 1'b0},
      '{32'hff0, 32'hfe0, 32'hfd0, 32'hfc0, 32'h010, 32'hffff_0000,
        1'b1, 1'b1, 1'b1, 4'b1111, 2'b11, 1'b1, 3'd0, 1'b1}
   };

   logic                              clk_main_a0;
   logic                              rst_main_n_sync;
   lvt_sources_t                      lvt_src;
   logic                              tq_empty;
   logic                              tsb_empty;
   logic                              all_cores_idle;
   logic            [n_threads-1:0]   thread_valid;
   finish_req_t     [n_threads-1:0]   thread_req;
   logic     [undo_log_threads-1:0]   restore_valid;
   cq_slot_t [undo_log_threads-1:0]   restore_slot;
   logic                              cq_ready;
   logic                              sel_valid;
   finish_sel_t                       sel;
   logic            [n_threads-1:0]   thread_ready;
   logic     [undo_log_threads-1:0]   restore_ready;
   vt_u                               lvt;
   logic                              done;

   integer                            seed = 32'h7d5c15c6;
   int                                error_count = 0;
   logic          [cycle_width-1:0]   cyc;
   vt_u                               last_lvt;
   tb_t                               pub_tb;
   logic                              prev_quiet;
   finish_req_t     [n_threads-1:0]   model_req;
   cq_slot_t [undo_log_threads-1:0]   model_rslot;

   tile_control DUT (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .lvt_src         (lvt_src),
      .tq_empty        (tq_empty),
      .tsb_empty       (tsb_empty),
      .all_cores_idle  (all_cores_idle),
      .thread_valid    (thread_valid),
      .thread_req      (thread_req),
      .restore_valid   (restore_valid),
      .restore_slot    (restore_slot),
      .cq_ready        (cq_ready),
      .sel_valid       (sel_valid),
      .sel             (sel),
      .thread_ready    (thread_ready),
      .restore_ready   (restore_ready),
      .lvt             (lvt),
      .done            (done)
   );

   task automatic fail_run();
      $display("Test FAILED");
      $fatal(1, "simulation stopped on a failed check");
   endtask

   `include "tile_control_checks.svh"

   initial begin
      clk_main_a0 = 1'b0;
      forever #(clk_period / 2) clk_main_a0 = ~clk_main_a0;
   end

   initial begin
      #(watchdog_ns);
      $display("The run timed out before all table rows were applied and checked");
      fail_run();
   end

   // Cycles since reset release as the tile counts them
   always @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         cyc <= '0;
      end else begin
         cyc <= cyc + 1'b1;
      end
   end

   // LVT may only move right after phase 10; remember the time base it was built on
   always @(negedge clk_main_a0) begin
      if (rst_main_n_sync) begin
         if ((lvt !== last_lvt) && (cyc[log_gvt_period-1:0] != lvt_publish_phase + 1'b1)) begin
            report_error($sformatf("lvt changed at phase %0d", cyc[log_gvt_period-1:0]));
         end
         if (cyc[log_gvt_period-1:0] == lvt_publish_phase) begin
            // Start of the period before the current one
            pub_tb = tb_t'(cyc) - tb_t'(lvt_publish_phase) - tb_t'(1 << log_gvt_period);
         end
      end
      last_lvt = lvt;
   end

   // Smallest time stamp wins; only the CQ brings its own time base
   function automatic vt_u expected_lvt(input stim_t row, input tb_t tb);
      vt_u exp;
      ts_t low;
      low = row.tq_ts;
      if (row.cm_ts < low) low = row.cm_ts;
      if (row.splitter_ts < low) low = row.splitter_ts;
      if (row.tsb_ts < low) low = row.tsb_ts;
      if (row.cq_ts < low) begin
         exp.fields.ts = row.cq_ts;
         exp.fields.tb = row.cq_tb;
      end else begin
         exp.fields.ts = low;
         exp.fields.tb = tb;
      end
      return exp;
   endfunction

   task automatic compare_finish(input string what, input stim_t row);
      logic                        exp_valid;
      finish_sel_t                 exp_sel;
      logic [n_threads-1:0]        exp_tready;
      logic [undo_log_threads-1:0] exp_rready;
      int                          core;
      core         = int'(row.exp_core);
      exp_valid    = |{row.restore_valid, row.thread_valid};
      exp_sel      = '0;
      exp_sel.core = row.exp_core;
      exp_tready   = '0;
      exp_rready   = '0;
      if (core < n_threads) begin
         exp_sel.slot           = model_req[core].slot;
         exp_sel.num_children   = model_req[core].num_children;
         exp_sel.undo_log_write = model_req[core].undo_log_write;
         exp_tready[core]       = exp_valid & row.cq_ready;
      end else begin
         exp_sel.slot                 = model_rslot[core - n_threads];
         exp_sel.is_restore           = 1'b1;
         exp_rready[core - n_threads] = exp_valid & row.cq_ready;
      end
      check_finish(what, sel_valid, sel, thread_ready, restore_ready,
         exp_valid, exp_sel, exp_tready, exp_rready);
   endtask

   task automatic apply_row(input int i);
      stim_t        row;
      lvt_sources_t src;
      row = stim_table[i];
      for (int t = 0; t < n_threads; t++) begin
         model_req[t] = finish_req_t'($random(seed));
      end
      for (int r = 0; r < undo_log_threads; r++) begin
         model_rslot[r] = cq_slot_t'($random(seed));
      end
      src.tq_ts           = row.tq_ts;
      src.cm_ts           = row.cm_ts;
      src.splitter_ts     = row.splitter_ts;
      src.tsb_ts          = row.tsb_ts;
      src.cq_vt.fields.ts = row.cq_ts;
      src.cq_vt.fields.tb = row.cq_tb;
      lvt_src        <= src;
      tq_empty       <= row.tq_empty;
      tsb_empty      <= row.tsb_empty;
      all_cores_idle <= row.all_cores_idle;
      thread_valid   <= row.thread_valid;
      thread_req     <= model_req;
      restore_valid  <= row.restore_valid;
      restore_slot   <= model_rslot;
      cq_ready       <= row.cq_ready;
   endtask

   initial begin
      rst_main_n_sync = 1'b0;
      lvt_src         = '0;
      tq_empty        = 1'b0;
      tsb_empty       = 1'b0;
      all_cores_idle  = 1'b0;
      thread_valid    = '0;
      thread_req      = '0;
      restore_valid   = '0;
      restore_slot    = '0;
      cq_ready        = 1'b0;
      prev_quiet      = 1'b0;
      repeat (2) @(posedge clk_main_a0);
      rst_main_n_sync <= 1'b1;
      @(negedge clk_main_a0);
      check_bit("done after reset", done, 1'b0);

      // Finish selection and done over two cycles per row
      for (int i = 0; i < n_rows; i++) begin
         @(posedge clk_main_a0);
         apply_row(i);
         @(negedge clk_main_a0);
         check_bit($sformatf("done one cycle into row %0d", i), done, prev_quiet);
         compare_finish($sformatf("finish row %0d", i), stim_table[i]);
         @(posedge clk_main_a0);
         @(negedge clk_main_a0);
         check_bit($sformatf("done row %0d", i), done, stim_table[i].exp_done);
         compare_finish($sformatf("finish row %0d", i), stim_table[i]);
         prev_quiet = stim_table[i].exp_done;
      end

      // Each LVT row starts at phase 0 and lasts three whole periods
      do @(posedge clk_main_a0); while (cyc[log_gvt_period-1:0] != '1);
      for (int i = 0; i < n_rows; i++) begin
         apply_row(i);
         repeat (lvt_hold_cycles - 1) @(posedge clk_main_a0);
         @(negedge clk_main_a0);
         check_vt($sformatf("lvt row %0d", i), lvt, expected_lvt(stim_table[i], pub_tb));
         compare_finish($sformatf("finish in lvt row %0d", i), stim_table[i]);
         @(posedge clk_main_a0);
      end

      if (error_count == 0) begin
         $display("Test OK");
         $finish;
      end else begin
         fail_run();
      end
   end

endmodule

`default_nettype wire
